// ==== Makefile ====
# Verilator flow for the conversion unit

TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = fcvt_tb
FILELIST   = build.f
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
+incdir+rtl
rtl/fcvt_pkg.sv
rtl/fcvt_norm_if.sv
rtl/fcvt_f2i.sv
rtl/fcvt_i2f_norm.sv
rtl/fcvt_i2f_round.sv
rtl/fcvt_unit.sv
verification/fcvt_sva.sv
verification/fcvt_tb.sv

// ==== rtl/fcvt_f2i.sv ====
// ------------------------------------------------------------
// Float to int32/uint32 in one registered stage
// Classify, align, round, then saturate out-of-range values
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_f2i import fcvt_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        start,
  input  logic        is_unsigned,
  input  round_mode_e rm,
  input  fp_word_t    operand,
  output int_word_t   result,
  output logic        flag_nv,
  output logic        flag_nx
);

  localparam int SIG_W  = `FCVT_MAN_W + 1;
  // Fraction depth where no significand bit falls off the bottom
  localparam int FRAC_W = SIG_W + 2;
  localparam int SHR_W  = SIG_W + FRAC_W;
  localparam int_word_t SMIN = int_word_t'(1) << (`FCVT_INT_W - 1);
  localparam int_word_t SMAX = ~SMIN;

  // Fields and class
  logic              sign;
  exp_t              exp_f;
  man_t              man_f;
  logic              is_nan;
  logic              is_inf;
  logic              is_tiny_exp;
  logic signed [9:0] exp_unb;
  logic [SIG_W-1:0]  sig;

  // Alignment
  logic [4:0]        rsh;
  logic [3:0]        lsh;
  logic [SHR_W-1:0]  shr;
  int_word_t         mag;
  logic              g_bit;
  logic              r_bit;
  logic              s_bit;

  // Rounding and range
  logic                 inc;
  logic [`FCVT_INT_W:0] rounded;
  logic                 too_big;
  logic                 ovf;
  int_word_t            res_d;
  logic                 nv_d;
  logic                 nx_d;

  assign sign        = operand[`FCVT_EXP_W+`FCVT_MAN_W];
  assign exp_f       = operand[`FCVT_EXP_W+`FCVT_MAN_W-1:`FCVT_MAN_W];
  assign man_f       = operand[`FCVT_MAN_W-1:0];
  assign is_nan      = (exp_f == '1) && (man_f != '0);
  assign is_inf      = (exp_f == '1) && (man_f == '0);
  // Zero and subnormal share the zero exponent
  assign is_tiny_exp = (exp_f == '0);
  assign sig         = {1'b1, man_f};
  assign exp_unb     = 10'(exp_f) - 10'(`FCVT_BIAS);
  assign too_big     = (exp_unb >= `FCVT_INT_W);

  // Shift amounts are only used inside their valid exponent window
  assign rsh = 5'(`FCVT_MAN_W - exp_unb);
  assign lsh = 4'(exp_unb - `FCVT_MAN_W);
  assign shr = {sig, {FRAC_W{1'b0}}} >> rsh;

  // Integer part plus guard/round/sticky
  always_comb begin
    mag   = '0;
    g_bit = 1'b0;
    r_bit = 1'b0;
    s_bit = 1'b0;
    if (is_tiny_exp) begin
      // Subnormal is a tiny nonzero, zero stays exact
      s_bit = (man_f != '0);
    end else if (exp_unb >= `FCVT_MAN_W) begin
      // Whole number, no fraction
      mag = int_word_t'(sig) << lsh;
    end else if (exp_unb >= `FCVT_MAN_W - FRAC_W) begin
      mag   = int_word_t'(shr[SHR_W-1:FRAC_W]);
      g_bit = shr[FRAC_W-1];
      r_bit = shr[FRAC_W-2];
      s_bit = |shr[FRAC_W-3:0];
    end else begin
      s_bit = 1'b1;
    end
  end

  assign inc     = round_increment(rm, sign, mag[0], g_bit, r_bit, s_bit);
  assign rounded = {1'b0, mag} + (`FCVT_INT_W+1)'(inc);

  // Range check on the rounded magnitude, so a carry past the limit saturates
  always_comb begin
    if (is_unsigned) begin
      ovf = sign ? (rounded != '0) : rounded[`FCVT_INT_W];
    end else begin
      ovf = sign ? (rounded > {1'b0, SMIN}) : (rounded > {1'b0, SMAX});
    end
    ovf = ovf | too_big | is_inf;
  end

  always_comb begin
    res_d = '0;
    nv_d  = 1'b0;
    nx_d  = 1'b0;
    if (is_nan) begin
      // NaN saturates positive whatever its sign
      res_d = is_unsigned ? '1 : SMAX;
      nv_d  = 1'b1;
    end else if (ovf) begin
      if (sign) res_d = is_unsigned ? '0 : SMIN;
      else      res_d = is_unsigned ? '1 : SMAX;
      nv_d = 1'b1;
    end else begin
      res_d = sign ? -rounded[`FCVT_INT_W-1:0] : rounded[`FCVT_INT_W-1:0];
      nx_d  = g_bit | r_bit | s_bit;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nv <= 1'b0;
      flag_nx <= 1'b0;
    end else if (start) begin
      result  <= res_d;
      flag_nv <= nv_d;
      flag_nx <= nx_d;
    end
  end

endmodule

// ==== rtl/fcvt_i2f_norm.sv ====
// ------------------------------------------------------------
// Int-to-float first stage: sign/magnitude, leading-zero count
// Registers the normalized value onto the norm interface
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_i2f_norm import fcvt_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      start,
  input  logic      is_unsigned,
  input  int_word_t operand,
  fcvt_norm_if.producer norm
);

  // Position of the guard bit once the msb sits at the top
  localparam int G_POS = `FCVT_INT_W - 2 - `FCVT_MAN_W;

  logic      neg;
  int_word_t abs_val;
  lz_count_t lz;
  int_word_t shifted;
  exp_t      exp_d;

  // Unsigned ops never see a sign
  assign neg     = !is_unsigned && operand[`FCVT_INT_W-1];
  // -2^31 maps onto 0x80000000 as a magnitude
  assign abs_val = neg ? -operand : operand;

  // Priority encoder, highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < `FCVT_INT_W; i++) begin
      if (abs_val[i]) lz = lz_count_t'(`FCVT_INT_W - 1 - i);
    end
  end

  // Msb lands on the top bit, next bits are the stored mantissa
  assign shifted = abs_val << lz;
  assign exp_d   = exp_t'(`FCVT_BIAS + `FCVT_INT_W - 1) - exp_t'(lz);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      norm.sign   <= 1'b0;
      norm.exp    <= '0;
      norm.man    <= '0;
      norm.guard  <= 1'b0;
      norm.round  <= 1'b0;
      norm.sticky <= 1'b0;
    end else if (start) begin
      if (abs_val == '0) begin
        // Zero has no leading one, send an all-zero value
        norm.sign   <= 1'b0;
        norm.exp    <= '0;
        norm.man    <= '0;
        norm.guard  <= 1'b0;
        norm.round  <= 1'b0;
        norm.sticky <= 1'b0;
      end else begin
        norm.sign   <= neg;
        norm.exp    <= exp_d;
        norm.man    <= shifted[`FCVT_INT_W-2 -: `FCVT_MAN_W];
        norm.guard  <= shifted[G_POS];
        norm.round  <= shifted[G_POS-1];
        norm.sticky <= |shifted[G_POS-2:0];
      end
    end
  end

endmodule

// ==== rtl/fcvt_i2f_round.sv ====
// ------------------------------------------------------------
// Int-to-float second stage: rounds the normalized mantissa
// ------------------------------------------------------------
`timescale 1ns/100ps

module fcvt_i2f_round import fcvt_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        start,
  input  round_mode_e rm,
  fcvt_norm_if.consumer norm,
  output fp_word_t    result,
  output logic        flag_nx
);

  logic inc;
  logic carry;
  man_t man_rnd;
  exp_t exp_rnd;

  // Decision uses the mantissa lsb for ties to even
  assign inc = round_increment(rm, norm.sign, norm.man[0], norm.guard, norm.round,
                               norm.sticky);

  // All-ones mantissa wraps to zero and bumps the exponent
  assign {carry, man_rnd} = {1'b0, norm.man} + {{$bits(man_t){1'b0}}, inc};
  assign exp_rnd          = norm.exp + exp_t'(carry);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nx <= 1'b0;
    end else if (start) begin
      result  <= {norm.sign, exp_rnd, man_rnd};
      // Any bit below the lsb makes it inexact
      flag_nx <= norm.guard | norm.round | norm.sticky;
    end
  end

endmodule

// ==== rtl/fcvt_norm_if.sv ====
// ------------------------------------------------------------
// Normalized int-to-float value passed from normalize to round
// ------------------------------------------------------------
`timescale 1ns/100ps

interface fcvt_norm_if import fcvt_pkg::*; ();

  logic sign;
  // Biased exponent and the mantissa without the implicit one
  exp_t exp;
  man_t man;
  // Bits below the mantissa lsb
  logic guard;
  logic round;
  logic sticky;

  modport producer (output sign, exp, man, guard, round, sticky);

  modport consumer (input sign, exp, man, guard, round, sticky);

endinterface

// ==== rtl/fcvt_pkg.sv ====
// ------------------------------------------------------------
// Shared types and the rounding decision for the FP converter
// ------------------------------------------------------------
`include "fcvt_settings.svh"

package fcvt_pkg;

  // Word and field types
  typedef logic [`FCVT_EXP_W+`FCVT_MAN_W:0]   fp_word_t;
  typedef logic [`FCVT_INT_W-1:0]              int_word_t;
  typedef logic [`FCVT_EXP_W-1:0]              exp_t;
  typedef logic [`FCVT_MAN_W-1:0]              man_t;
  typedef logic [$clog2(`FCVT_INT_W)-1:0]      lz_count_t;

  // Bit 0 selects unsigned, bit 1 selects int-to-float
  typedef enum logic [`FCVT_OP_W-1:0] {
    op_w_s  = 2'd0,
    op_wu_s = 2'd1,
    op_s_w  = 2'd2,
    op_s_wu = 2'd3
  } fcvt_op_e;

  // IEEE rounding modes, codes 5..7 reserved
  typedef enum logic [`FCVT_RM_W-1:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } round_mode_e;

  typedef enum logic [1:0] {st_idle, st_convert, st_round, st_done} seq_state_e;

  // True when the truncated magnitude must go up by one
  function automatic logic round_increment(input round_mode_e mode, input logic sign,
                                           input logic lsb, input logic guard,
                                           input logic round, input logic sticky);
    logic any_lost;
    any_lost = guard | round | sticky;
    case (mode)
      rne:     return guard & (round | sticky | lsb);
      rdn:     return sign & any_lost;
      rup:     return !sign & any_lost;
      rmm:     return guard;
      // RTZ and reserved codes truncate
      default: return 1'b0;
    endcase
  endfunction

endpackage

// ==== rtl/fcvt_settings.svh ====
// ------------------------------------------------------------
// Width, bias and code-size macros for the conversion unit
// Include wherever a width or the exponent bias is needed
// ------------------------------------------------------------
`ifndef FCVT_SETTINGS_SVH
`define FCVT_SETTINGS_SVH

// Single-precision field widths
`define FCVT_EXP_W 8
`define FCVT_MAN_W 23
`define FCVT_BIAS  127

// Integer side is RV32 only
`define FCVT_INT_W 32

// Control field widths
`define FCVT_OP_W  2
`define FCVT_RM_W  3

`endif

// ==== rtl/fcvt_unit.sv ====
// ------------------------------------------------------------
// Single-precision FP/int32 converter with valid/ready on both sides
// One request in flight and the result is shown in st_done
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "fcvt_settings.svh"

module fcvt_unit import fcvt_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [`FCVT_OP_W-1:0] op,
  input  logic [`FCVT_RM_W-1:0] rm,
  input  logic [`FCVT_INT_W-1:0] operand,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`FCVT_INT_W-1:0] result,
  output logic                  flag_nv,
  output logic                  flag_nx
);

  seq_state_e state;
  seq_state_e state_nxt;

  // Latched request
  fcvt_op_e              op_q;
  logic [`FCVT_RM_W-1:0] rm_q;
  int_word_t             operand_q;

  // Per-path registered outputs
  int_word_t f2i_result;
  logic      f2i_nv;
  logic      f2i_nx;
  fp_word_t  i2f_result;
  logic      i2f_nx;

  logic to_float;
  logic rm_legal;

  fcvt_norm_if norm_bus ();

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_comb begin
    case (state)
      st_idle:    state_nxt = in_valid ? st_convert : st_idle;
      st_convert: state_nxt = st_round;
      st_round:   state_nxt = st_done;
      // Hold the result until the consumer takes it
      default:    state_nxt = out_ready ? st_idle : st_done;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      op_q  <= op_w_s;
      rm_q  <= '0;
    end else begin
      state <= state_nxt;
      if (in_valid && in_ready) begin
        op_q <= fcvt_op_e'(op);
        rm_q <= rm;
      end
    end
  end

  // Operand captured when a request is accepted
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      operand_q <= operand;
    end
  end

  assign in_ready  = (state == st_idle);
  assign out_valid = (state == st_done);
  assign to_float  = op_q inside {op_s_w, op_s_wu};
  assign rm_legal  = (rm_q <= `FCVT_RM_W'(rmm));

  // ------------------------------------------------------------
  // Datapaths
  // ------------------------------------------------------------
  fcvt_f2i f2i_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       ((state == st_convert) && !to_float),
    .is_unsigned (op_q[0]),
    .rm          (round_mode_e'(rm_q)),
    .operand     (operand_q),
    .result      (f2i_result),
    .flag_nv     (f2i_nv),
    .flag_nx     (f2i_nx)
  );

  fcvt_i2f_norm i2f_norm_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       ((state == st_convert) && to_float),
    .is_unsigned (op_q[0]),
    .operand     (operand_q),
    .norm        (norm_bus.producer)
  );

  fcvt_i2f_round i2f_round_i (
    .clk     (clk),
    .reset_n (reset_n),
    .start   ((state == st_round) && to_float),
    .rm      (round_mode_e'(rm_q)),
    .norm    (norm_bus.consumer),
    .result  (i2f_result),
    .flag_nx (i2f_nx)
  );

  // Result select
  // Reserved rounding modes give zero and no flags
  always_comb begin
    result  = '0;
    flag_nv = 1'b0;
    flag_nx = 1'b0;
    if (rm_legal && to_float) begin
      result  = i2f_result;
      flag_nx = i2f_nx;
    end else if (rm_legal) begin
      result  = f2i_result;
      flag_nv = f2i_nv;
      flag_nx = f2i_nx;
    end
  end

endmodule

// ==== verification/fcvt_sva.sv ====
// ------------------------------------------------------------
// Handshake and flag assertions, bound into the converter top
// ------------------------------------------------------------
`timescale 1ns/100ps

module fcvt_sva (
  input logic        clk,
  input logic        reset_n,
  input logic        in_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] result,
  input logic        flag_nv,
  input logic        flag_nx,
  input logic [1:0]  op_q
);

  // Response payload holds while the consumer stalls
  hold_under_stall: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flag_nv)
                                && $stable(flag_nx))
    else $error("response changed under back-pressure");

  // One conversion in flight
  no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
    !(in_ready && out_valid))
    else $error("in_ready and out_valid high together");

  // Int-to-float never raises invalid
  no_nv_to_float: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid && op_q[1] |-> !flag_nv)
    else $error("flag_nv set on an int-to-float result");

endmodule

bind fcvt_unit fcvt_sva sva_i (
  .clk       (clk),
  .reset_n   (reset_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .result    (result),
  .flag_nv   (flag_nv),
  .flag_nx   (flag_nx),
  .op_q      (op_q)
);

// ==== verification/fcvt_tb.sv ====
// ------------------------------------------------------------
// Testbench for the FP/int32 converter with random and directed
// cases checked against an integer reference model
// ------------------------------------------------------------
`timescale 1ns/100ps

module fcvt_tb;

  logic        clk;
  logic        reset_n;
  logic        in_valid;
  logic        in_ready;
  logic [1:0]  op;
  logic [2:0]  rm;
  logic [31:0] operand;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] result;
  logic        flag_nv;
  logic        flag_nx;

  logic [31:0] rng;
  int          errors;
  int          tests;
  int          convs;
  bit          aborted;

  // Exact halves and quarters for the tie cases
  logic [31:0] halves [6] = '{32'h3f00_0000, 32'h3fc0_0000, 32'h4020_0000,
                              32'hbf00_0000, 32'h3e80_0000, 32'hc060_0000};
  // NaN, infinities and values at the edge of the integer range
  logic [31:0] specials [10] = '{32'h7fc0_0000, 32'hffc0_0000, 32'h7f80_0000,
                                 32'hff80_0000, 32'h4f00_0000, 32'hcf00_0000,
                                 32'h4f80_0000, 32'hcf00_0001, 32'hbf80_0000,
                                 32'h4eff_ffff};

  fcvt_unit dut_i (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Rounding decision from the lost fraction
  // cmp is -1, 0 or 1 for below, at or above one half
  function automatic logic bump(input logic [2:0] mode, input logic sign, input logic odd,
                                input int cmp, input logic lost);
    case (mode)
      3'd0:    return (cmp > 0) || (cmp == 0 && odd);
      3'd2:    return sign && lost;
      3'd3:    return !sign && lost;
      3'd4:    return cmp >= 0;
      default: return 1'b0;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  task automatic model(input logic [1:0] m_op, input logic [2:0] m_rm, input logic [31:0] x,
                       output logic [31:0] res, output logic nv, output logic nx);
    logic [63:0] mag;
    logic [63:0] ip;
    logic [63:0] rem;
    logic [63:0] half;
    logic        sign;
    logic        lost;
    logic        big;
    int          cmp;
    int          eu;
    int          sh;
    int          p;
    res = '0;
    nv = 1'b0;
    nx = 1'b0;
    ip = '0;
    lost = 1'b0;
    big = 1'b0;
    cmp = -1;
    if (m_rm > 3'd4) return;
    if (m_op[1]) begin
      // Int to float
      sign = !m_op[0] && x[31];
      mag = sign ? (64'd1 << 32) - 64'(x) : 64'(x);
      if (mag == 0) return;
      p = 0;
      for (int i = 0; i < 33; i++) begin
        if (mag[i]) p = i;
      end
      if (p <= 23) begin
        ip = mag << (23 - p);
      end else begin
        sh = p - 23;
        ip = mag >> sh;
        rem = mag & ((64'd1 << sh) - 1);
        half = 64'd1 << (sh - 1);
        lost = (rem != 0);
        if (lost) cmp = (rem > half) ? 1 : ((rem == half) ? 0 : -1);
      end
      ip = ip + 64'(bump(m_rm, sign, ip[0], cmp, lost));
      if (ip[24]) begin
        ip = ip >> 1;
        p++;
      end
      res = {sign, 8'(127 + p), ip[22:0]};
      nx = lost;
      return;
    end
    // Float to int
    sign = x[31];
    if (x[30:23] == 8'hff && x[22:0] != 0) begin
      res = m_op[0] ? 32'hffff_ffff : 32'h7fff_ffff;
      nv = 1'b1;
      return;
    end
    if (x[30:23] == 8'hff) begin
      big = 1'b1;
    end else if (x[30:23] == 0) begin
      lost = (x[22:0] != 0);
    end else begin
      eu = int'(x[30:23]) - 127;
      mag = {40'd1, x[22:0]};
      if (eu >= 32) begin
        big = 1'b1;
      end else if (eu >= 23) begin
        ip = mag << (eu - 23);
      end else begin
        sh = 23 - eu;
        if (sh >= 40) begin
          lost = 1'b1;
        end else begin
          ip = mag >> sh;
          rem = mag & ((64'd1 << sh) - 1);
          half = 64'd1 << (sh - 1);
          lost = (rem != 0);
          if (lost) cmp = (rem > half) ? 1 : ((rem == half) ? 0 : -1);
        end
      end
    end
    ip = ip + 64'(bump(m_rm, sign, ip[0], cmp, lost));
    if (!big && m_op[0]) big = sign ? (ip != 0) : (ip >= 64'h1_0000_0000);
    if (!big && !m_op[0]) big = sign ? (ip > 64'h8000_0000) : (ip > 64'h7fff_ffff);
    if (big) begin
      nv = 1'b1;
      if (sign) res = m_op[0] ? 32'h0 : 32'h8000_0000;
      else      res = m_op[0] ? 32'hffff_ffff : 32'h7fff_ffff;
    end else begin
      res = sign ? -ip[31:0] : ip[31:0];
      nx = lost;
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("error %s got %h expected %h (op %0d rm %0d operand %h)",
               name, got, exp, op, rm, operand);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // One request through both handshakes
  // Entered and left on a falling edge
  // ------------------------------------------------------------
  task automatic convert(input logic [1:0] c_op, input logic [2:0] c_rm,
                         input logic [31:0] c_x, input bit stall);
    logic [31:0] e_res;
    logic        e_nv;
    logic        e_nx;
    int          n;
    if (aborted) return;
    model(c_op, c_rm, c_x, e_res, e_nv, e_nx);
    in_valid = 1'b1;
    op = c_op;
    rm = c_rm;
    operand = c_x;
    out_ready = !stall;
    n = 0;
    while (!in_ready && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!in_ready) begin
      $display("timeout: request was never accepted");
      aborted = 1;
      return;
    end
    @(negedge clk);
    in_valid = 1'b0;
    n = 1;
    while (!out_valid && n < 20) begin
      assert (!in_ready)
      else begin
        $display("in_ready rose while a conversion was running");
        errors++;
      end
      @(negedge clk);
      n++;
    end
    if (!out_valid) begin
      $display("timeout: no result after an accepted request");
      aborted = 1;
      return;
    end
    assert (n == 3)
    else begin
      $display("out_valid came %0d cycles after acceptance instead of 3", n);
      errors++;
    end
    // Values are checked on every cycle the result is held
    n = 0;
    do begin
      check_val("result", result, e_res);
      check_val("flag_nv", 32'(flag_nv), 32'(e_nv));
      check_val("flag_nx", 32'(flag_nx), 32'(e_nx));
      assert (!in_ready)
      else begin
        $display("in_ready high while a result was waiting to be taken");
        errors++;
      end
      rng = xorshift(rng);
      out_ready = !stall || rng[0] || (n > 8);
      @(negedge clk);
      n++;
      if (!out_ready && !out_valid) begin
        $display("result dropped before it was taken");
        errors++;
      end
    end while (!out_ready && out_valid);
    out_ready = 1'b0;
    assert (!out_valid && in_ready)
    else begin
      $display("result was not released after it was taken");
      errors++;
    end
    convs++;
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    $display("test %-12s %s  (%0d errors)", name,
             (errors == errs_before && !aborted) ? "ok" : "bad", errors - errs_before);
  endtask

  // Float with an exponent spread around the integer range
  function automatic logic [31:0] rand_float(input logic [31:0] r, input logic [31:0] s);
    logic [7:0] e;
    e = r[3] ? 8'(118 + s[5:0] % 44) : r[11:4];
    return {r[31], e, r[2] ? {r[30:12], 4'h0} : r[22:0] ^ s[22:0]};
  endfunction

  initial begin
    int          base;
    logic [31:0] s;
    clk = 1'b0;
    reset_n = 1'b0;
    in_valid = 1'b0;
    op = '0;
    rm = '0;
    operand = '0;
    out_ready = 1'b0;
    rng = 32'h4d05_5fc3;
    errors = 0;
    tests = 0;
    convs = 0;
    aborted = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    base = errors;
    check_val("in_ready", 32'(in_ready), 32'd1);
    check_val("out_valid", 32'(out_valid), 32'd0);
    report("reset", base);

    base = errors;
    for (int i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      s = xorshift(rng);
      convert(rng[1:0], 3'(rng[4:2] % 5), rng[0] ? s : rand_float(rng, s), 0);
    end
    report("latency", base);

    base = errors;
    for (int m = 0; m < 5; m++) begin
      for (int u = 0; u < 2; u++) begin
        convert(2'(2 + u), 3'(m), 32'h01ff_ffff, 0);
        convert(2'(2 + u), 3'(m), 32'h8000_0000, 0);
        convert(2'(2 + u), 3'(m), 32'h00ff_ffff, 0);
        convert(2'(2 + u), 3'(m), 32'h0000_0000, 0);
      end
    end
    for (int i = 0; i < 300; i++) begin
      rng = xorshift(rng);
      s = xorshift(rng);
      convert({1'b1, rng[0]}, 3'(rng[3:1] % 5), s >> rng[8:4], 0);
    end
    report("int_to_float", base);

    base = errors;
    for (int m = 0; m < 5; m++) begin
      foreach (halves[k]) begin
        convert(2'd0, 3'(m), halves[k], 0);
        convert(2'd1, 3'(m), halves[k], 0);
      end
    end
    for (int i = 0; i < 300; i++) begin
      rng = xorshift(rng);
      s = xorshift(rng);
      convert({1'b0, rng[0]}, 3'(rng[3:1] % 5), rand_float(rng, s), 0);
    end
    report("float_to_int", base);

    base = errors;
    for (int m = 0; m < 8; m++) begin
      foreach (specials[k]) begin
        convert(2'd0, 3'(m), specials[k], 0);
        convert(2'd1, 3'(m), specials[k], 0);
      end
    end
    report("special", base);

    base = errors;
    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      s = xorshift(rng);
      convert(rng[1:0], 3'(rng[5:3]), rng[1] ? s : rand_float(rng, s), 1);
    end
    report("backpressure", base);

    $display("tests %0d  conversions %0d  errors %0d%s", tests, convs, errors,
             aborted ? "  (run aborted on timeout)" : "");
    if (errors == 0 && !aborted) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
